// File: Bender.yml
package:
  name: fir_filter

sources:
  # Synthesizable design
  - files:
      - src/fir_pkg.sv
      - src/fir_dp_ram.sv
      - src/fir_serial_core.sv
      - src/fir_tap_config.sv
      - src/fir_filter_top.sv

  # Simulation testbench
  - target: test
    files:
      - tb/tb_clock_gen.sv
      - tb/fir_checker.sv
      - tb/fir_filter_tb.sv

// File: fir_filter_top.f
src/fir_pkg.sv
src/fir_dp_ram.sv
src/fir_serial_core.sv
src/fir_tap_config.sv
src/fir_filter_top.sv
tb/tb_clock_gen.sv
tb/fir_checker.sv
tb/fir_filter_tb.sv

// File: src/fir_dp_ram.sv
// Simple dual-port RAM
`timescale 1ns/1ps

module fir_dp_ram #(
    parameter int WIDTH = 16,
    parameter int DEPTH = 16,
    localparam int ADDR_WIDTH = (DEPTH > 1) ? $clog2(DEPTH) : 1
) (
    input  logic                  clock,
    input  logic                  wr_en,
    input  logic [ADDR_WIDTH-1:0] wr_addr,
    input  logic [WIDTH-1:0]      wr_data,
    input  logic [ADDR_WIDTH-1:0] rd_addr,
    output logic [WIDTH-1:0]      rd_data
);

    logic [WIDTH-1:0] mem [DEPTH];

    // Power-up image of all zeros
    initial begin
        for (int i = 0; i < DEPTH; i++) begin
            mem[i] = '0;
        end
    end

    // Write port
    always_ff @(posedge clock) begin
        if (wr_en) begin
            mem[wr_addr] <= wr_data;
        end
    end

    // Registered read port, returns the old word when both ports hit one address
    always_ff @(posedge clock) begin
        rd_data <= mem[rd_addr];
    end

endmodule

// File: src/fir_filter_top.sv
// Programmable FIR filter top level
`timescale 1ns/1ps

module fir_filter_top #(
    parameter int DATA_WIDTH = 16,
    parameter int TAP_WIDTH  = 16,
    parameter int MAX_N_TAPS = 16,
    localparam int ADDR_WIDTH = (MAX_N_TAPS > 1) ? $clog2(MAX_N_TAPS) : 1
) (
    input  logic                  clock,
    input  logic                  arst_n,

    // Configuration stream
    input  fir_pkg::cfg_cmd_t     cfg,
    input  logic                  cfg_valid,
    output logic                  cfg_ready,

    // Input sample stream
    input  logic [DATA_WIDTH-1:0] in_data,
    input  logic                  in_valid,
    output logic                  in_ready,

    // Output sample stream
    output logic [DATA_WIDTH-1:0] out_data,
    output logic                  out_valid,
    input  logic                  out_ready
);

    fir_pkg::tap_write_t   tap_wr;
    logic                  tap_wr_valid;
    logic [ADDR_WIDTH-1:0] n_taps;
    logic                  clear_req;
    logic                  busy;

    fir_tap_config #(
        .MAX_N_TAPS (MAX_N_TAPS)
    ) u_tap_config (
        .clock        (clock),
        .arst_n       (arst_n),
        .cfg          (cfg),
        .cfg_valid    (cfg_valid),
        .cfg_ready    (cfg_ready),
        .tap_wr       (tap_wr),
        .tap_wr_valid (tap_wr_valid),
        .n_taps       (n_taps),
        .clear_req    (clear_req),
        .busy         (busy)
    );

    fir_serial_core #(
        .DATA_WIDTH (DATA_WIDTH),
        .TAP_WIDTH  (TAP_WIDTH),
        .MAX_N_TAPS (MAX_N_TAPS)
    ) u_core (
        .clock        (clock),
        .arst_n       (arst_n),
        .n_taps       (n_taps),
        .tap_wr       (tap_wr),
        .tap_wr_valid (tap_wr_valid),
        .clear_req    (clear_req),
        .in_data      (in_data),
        .in_valid     (in_valid),
        .in_ready     (in_ready),
        .out_data     (out_data),
        .out_valid    (out_valid),
        .out_ready    (out_ready),
        .busy         (busy)
    );

endmodule

// File: src/fir_pkg.sv
// FIR filter shared definitions
package fir_pkg;

    // Width of the coefficient index on the configuration bus
    localparam int CFG_ADDR_WIDTH = 8;

    // Width of the coefficient or length field on the configuration bus
    localparam int CFG_DATA_WIDTH = 16;

    // Configuration opcodes
    typedef enum logic [1:0] {
        // Write one coefficient at addr with the value in data
        cfg_write_tap     = 2'd0,
        // Set the highest active tap index from data and clear the history
        cfg_set_length    = 2'd1,
        // Zero the delay line and keep the coefficients
        cfg_clear_history = 2'd2
    } cfg_op_t;

    // One command on the configuration stream
    typedef struct packed {
        cfg_op_t                   op;
        logic [CFG_ADDR_WIDTH-1:0] addr;
        logic [CFG_DATA_WIDTH-1:0] data;
    } cfg_cmd_t;

    // One coefficient write from the configuration block to the core
    // The coefficient sits right-aligned in data
    typedef struct packed {
        logic [CFG_ADDR_WIDTH-1:0] addr;
        logic [CFG_DATA_WIDTH-1:0] data;
    } tap_write_t;

endpackage

// File: src/fir_serial_core.sv
// Serial MAC FIR engine
`timescale 1ns/1ps

module fir_serial_core #(
    parameter int DATA_WIDTH = 16,
    parameter int TAP_WIDTH  = 16,
    parameter int MAX_N_TAPS = 16,
    localparam int ADDR_WIDTH = (MAX_N_TAPS > 1) ? $clog2(MAX_N_TAPS) : 1
) (
    input  logic                  clock,
    input  logic                  arst_n,
    input  logic [ADDR_WIDTH-1:0] n_taps,
    input  fir_pkg::tap_write_t   tap_wr,
    input  logic                  tap_wr_valid,
    input  logic                  clear_req,
    input  logic [DATA_WIDTH-1:0] in_data,
    input  logic                  in_valid,
    output logic                  in_ready,
    output logic [DATA_WIDTH-1:0] out_data,
    output logic                  out_valid,
    input  logic                  out_ready,
    output logic                  busy
);

    // Arithmetic runs at the wider of the two operand widths
    localparam int WORK_WIDTH = (DATA_WIDTH > TAP_WIDTH) ? DATA_WIDTH : TAP_WIDTH;
    localparam int ACC_WIDTH  = 2 * WORK_WIDTH;

    // Both operands are left-aligned, so the product carries an extra scale of
    // 2**(ACC_WIDTH-TAP_WIDTH-DATA_WIDTH); folding that into the TAP_WIDTH-1
    // rescale leaves the output at a fixed bit position
    localparam int OUT_LSB = ACC_WIDTH - DATA_WIDTH - 1;

    typedef enum logic [1:0] {
        state_clearing,
        state_idle,
        state_running,
        state_done
    } state_t;

    state_t state;

    logic [ADDR_WIDTH-1:0] clr_cnt;
    logic [ADDR_WIDTH-1:0] wr_ptr;
    logic [ADDR_WIDTH-1:0] rd_ptr;
    logic [ADDR_WIDTH-1:0] tap_cnt;

    // MAC pipeline flags: read issue, product valid, last product, result ready
    logic issue;
    logic mac_en;
    logic mac_last;
    logic fin;

    logic in_fire;

    logic                  dl_wr_en;
    logic [ADDR_WIDTH-1:0] dl_wr_addr;
    logic [DATA_WIDTH-1:0] dl_wr_data;

    logic [TAP_WIDTH-1:0]  coef_rd;
    logic [DATA_WIDTH-1:0] hist_rd;

    logic signed [WORK_WIDTH-1:0] coef_aligned;
    logic signed [WORK_WIDTH-1:0] hist_aligned;
    logic signed [ACC_WIDTH-1:0]  product;
    logic signed [ACC_WIDTH-1:0]  acc;

    // A pending clear request wins over a new sample
    assign in_ready  = (state == state_idle) && !clear_req;
    assign in_fire   = in_valid && in_ready;
    assign out_valid = (state == state_done);

    // A waiting input sample also holds configuration off, so a coefficient
    // write can never land in the middle of the sample it arrives with
    assign busy = (state != state_idle) || in_valid;

    fir_dp_ram #(
        .WIDTH (TAP_WIDTH),
        .DEPTH (MAX_N_TAPS)
    ) coef_mem (
        .clock   (clock),
        .wr_en   (tap_wr_valid),
        .wr_addr (tap_wr.addr[ADDR_WIDTH-1:0]),
        .wr_data (tap_wr.data[TAP_WIDTH-1:0]),
        .rd_addr (tap_cnt),
        .rd_data (coef_rd)
    );

    // The clearing pass owns the delay-line write port
    always_comb begin
        if (state == state_clearing) begin
            dl_wr_en   = 1'b1;
            dl_wr_addr = clr_cnt;
            dl_wr_data = '0;
        end else begin
            dl_wr_en   = in_fire;
            dl_wr_addr = wr_ptr;
            dl_wr_data = in_data;
        end
    end

    fir_dp_ram #(
        .WIDTH (DATA_WIDTH),
        .DEPTH (MAX_N_TAPS)
    ) delay_mem (
        .clock   (clock),
        .wr_en   (dl_wr_en),
        .wr_addr (dl_wr_addr),
        .wr_data (dl_wr_data),
        .rd_addr (rd_ptr),
        .rd_data (hist_rd)
    );

    assign coef_aligned = WORK_WIDTH'(coef_rd) << (WORK_WIDTH - TAP_WIDTH);
    assign hist_aligned = WORK_WIDTH'(hist_rd) << (WORK_WIDTH - DATA_WIDTH);
    assign product      = coef_aligned * hist_aligned;

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            state    <= state_clearing;
            clr_cnt  <= '0;
            wr_ptr   <= '0;
            rd_ptr   <= '0;
            tap_cnt  <= '0;
            issue    <= 1'b0;
            mac_en   <= 1'b0;
            mac_last <= 1'b0;
            fin      <= 1'b0;
        end else begin
            // Read data shows up one cycle after its address
            mac_en   <= issue;
            mac_last <= issue && (tap_cnt == n_taps);
            fin      <= mac_last;

            case (state)
                state_clearing: begin
                    wr_ptr <= '0;
                    if (clr_cnt == ADDR_WIDTH'(MAX_N_TAPS - 1)) begin
                        clr_cnt <= '0;
                        state   <= state_idle;
                    end else begin
                        clr_cnt <= clr_cnt + 1'b1;
                    end
                end

                state_idle: begin
                    if (clear_req) begin
                        state <= state_clearing;
                    end else if (in_fire) begin
                        // The newest sample is read first, then older ones
                        state   <= state_running;
                        issue   <= 1'b1;
                        tap_cnt <= '0;
                        rd_ptr  <= wr_ptr;
                        wr_ptr  <= (wr_ptr == n_taps) ? '0 : wr_ptr + 1'b1;
                    end
                end

                state_running: begin
                    if (issue) begin
                        rd_ptr <= (rd_ptr == '0) ? n_taps : rd_ptr - 1'b1;
                        if (tap_cnt == n_taps) begin
                            issue <= 1'b0;
                        end else begin
                            tap_cnt <= tap_cnt + 1'b1;
                        end
                    end
                    if (fin) begin
                        state <= state_done;
                    end
                end

                state_done: begin
                    if (out_ready) begin
                        state <= state_idle;
                    end
                end

                default: state <= state_clearing;
            endcase
        end
    end

    // Accumulator and output register, the sum wraps at ACC_WIDTH bits
    always_ff @(posedge clock) begin
        if (in_fire) begin
            acc <= '0;
        end else if (mac_en) begin
            acc <= acc + product;
        end
        if (fin) begin
            out_data <= acc[OUT_LSB +: DATA_WIDTH];
        end
    end

endmodule

// File: src/fir_tap_config.sv
// FIR configuration decoder
`timescale 1ns/1ps

module fir_tap_config #(
    parameter int MAX_N_TAPS = 16,
    localparam int ADDR_WIDTH = (MAX_N_TAPS > 1) ? $clog2(MAX_N_TAPS) : 1
) (
    input  logic                  clock,
    input  logic                  arst_n,
    input  fir_pkg::cfg_cmd_t     cfg,
    input  logic                  cfg_valid,
    output logic                  cfg_ready,
    output fir_pkg::tap_write_t   tap_wr,
    output logic                  tap_wr_valid,
    output logic [ADDR_WIDTH-1:0] n_taps,
    output logic                  clear_req,
    input  logic                  busy
);

    localparam int LAST_TAP = MAX_N_TAPS - 1;

    logic cfg_fire;
    logic tap_in_range;

    // Hold commands while the core works and during the cycle of a clear request
    assign cfg_ready = !busy && !clear_req;
    assign cfg_fire  = cfg_valid && cfg_ready;

    assign tap_in_range = int'(cfg.addr) < MAX_N_TAPS;

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            tap_wr_valid <= 1'b0;
            clear_req    <= 1'b0;
            n_taps       <= '0;
        end else begin
            tap_wr_valid <= 1'b0;
            clear_req    <= 1'b0;
            if (cfg_fire) begin
                case (cfg.op)
                    fir_pkg::cfg_write_tap: begin
                        // Writes beyond the RAM are dropped
                        tap_wr_valid <= tap_in_range;
                    end

                    fir_pkg::cfg_set_length: begin
                        if (int'(cfg.data) > LAST_TAP) begin
                            n_taps <= ADDR_WIDTH'(LAST_TAP);
                        end else begin
                            n_taps <= cfg.data[ADDR_WIDTH-1:0];
                        end
                        // A new length invalidates the history layout
                        clear_req <= 1'b1;
                    end

                    fir_pkg::cfg_clear_history: begin
                        clear_req <= 1'b1;
                    end

                    default: begin
                        tap_wr_valid <= 1'b0;
                    end
                endcase
            end
        end
    end

    // Coefficient payload, qualified by tap_wr_valid
    always_ff @(posedge clock) begin
        if (cfg_fire && (cfg.op == fir_pkg::cfg_write_tap)) begin
            tap_wr.addr <= cfg.addr;
            tap_wr.data <= cfg.data;
        end
    end

endmodule

// File: tb/fir_checker.sv
// FIR reference model and scoreboard
`timescale 1ns/1ps

module fir_checker #(
    parameter int DATA_WIDTH = 16,
    parameter int TAP_WIDTH  = 16,
    parameter int MAX_N_TAPS = 16
) (
    input logic                  clock,
    input logic                  arst_n,
    input fir_pkg::cfg_cmd_t     cfg,
    input logic                  cfg_valid,
    input logic                  cfg_ready,
    input logic [DATA_WIDTH-1:0] in_data,
    input logic                  in_valid,
    input logic                  in_ready,
    input logic [DATA_WIDTH-1:0] out_data,
    input logic                  out_valid,
    input logic                  out_ready
);

    localparam int WORK_WIDTH = (DATA_WIDTH > TAP_WIDTH) ? DATA_WIDTH : TAP_WIDTH;
    localparam int ACC_WIDTH  = 2 * WORK_WIDTH;

    string test_name = "reset";
    int    value_errors = 0;
    int    protocol_errors = 0;
    int    outputs_seen = 0;

    logic signed [TAP_WIDTH-1:0]  coef [MAX_N_TAPS];
    logic signed [DATA_WIDTH-1:0] hist [$];
    logic [DATA_WIDTH-1:0]        exp_q [$];
    int                           n_taps;
    logic                         seen_input;
    logic                         hold_pending;
    logic [DATA_WIDTH-1:0]        hold_data;

    function automatic int pending_count();
        return exp_q.size();
    endfunction

    // Sum of tap times sample, wrapped, shifted by TAP_WIDTH-1, cut to the data width
    function automatic logic [DATA_WIDTH-1:0] model_output();
        logic signed [ACC_WIDTH-1:0] sum;
        logic signed [ACC_WIDTH-1:0] a;
        logic signed [ACC_WIDTH-1:0] b;
        logic signed [ACC_WIDTH-1:0] shifted;
        sum = '0;
        for (int k = 0; k <= n_taps; k++) begin
            if (k < hist.size()) begin
                a = coef[k];
                b = hist[k];
                sum = sum + a * b;
            end
        end
        shifted = sum >>> (TAP_WIDTH - 1);
        return shifted[DATA_WIDTH-1:0];
    endfunction

    always @(posedge clock) begin
        if (!arst_n) begin
            if (out_valid) begin
                $display("Output valid was high during reset");
                protocol_errors++;
            end
            for (int i = 0; i < MAX_N_TAPS; i++) begin
                coef[i] = '0;
            end
            n_taps = 0;
            hist.delete();
            exp_q.delete();
            seen_input = 1'b0;
            hold_pending = 1'b0;
        end else begin
            if (out_valid && !seen_input) begin
                $display("Output valid rose before any input sample after reset");
                protocol_errors++;
            end
            if (hold_pending) begin
                if (!out_valid) begin
                    $display("Output valid dropped before the result was accepted");
                    protocol_errors++;
                end else if (out_data !== hold_data) begin
                    $display("FAIL %s stable out_data expected %h actual %h",
                             test_name, hold_data, out_data);
                    value_errors++;
                end
            end
            hold_pending = out_valid && !out_ready;
            hold_data    = out_data;

            if (out_valid && out_ready) begin
                outputs_seen++;
                if (exp_q.size() == 0) begin
                    $display("An output arrived with no matching input sample");
                    protocol_errors++;
                end else if (out_data !== exp_q[0]) begin
                    $display("FAIL %s output %0d expected %h actual %h",
                             test_name, outputs_seen, exp_q[0], out_data);
                    value_errors++;
                    void'(exp_q.pop_front());
                end else begin
                    void'(exp_q.pop_front());
                end
            end

            if (cfg_valid && cfg_ready) begin
                // Commands must never overlap a sample in flight
                if (exp_q.size() != 0 || (in_valid && in_ready)) begin
                    $display("A configuration command was accepted while a sample was in flight");
                    protocol_errors++;
                end
                case (cfg.op)
                    fir_pkg::cfg_write_tap: begin
                        if (int'(cfg.addr) < MAX_N_TAPS) begin
                            coef[cfg.addr] = cfg.data[TAP_WIDTH-1:0];
                        end
                    end
                    fir_pkg::cfg_set_length: begin
                        n_taps = (int'(cfg.data) > MAX_N_TAPS - 1) ?
                                 MAX_N_TAPS - 1 : int'(cfg.data);
                        hist.delete();
                    end
                    fir_pkg::cfg_clear_history: hist.delete();
                    default: ;
                endcase
            end

            // The expected value is fixed by the coefficients at the input transfer
            if (in_valid && in_ready) begin
                if (exp_q.size() != 0) begin
                    $display("An input sample was accepted before the previous result was taken");
                    protocol_errors++;
                end
                seen_input = 1'b1;
                hist.push_front(in_data);
                if (hist.size() > MAX_N_TAPS) begin
                    void'(hist.pop_back());
                end
                exp_q.push_back(model_output());
            end
        end
    end

endmodule

// File: tb/fir_filter_tb.sv
// FIR filter testbench
`timescale 1ns/1ps

module fir_filter_tb;

    localparam int DATA_WIDTH = 16;
    localparam int TAP_WIDTH  = 16;
    localparam int MAX_N_TAPS = 16;
    localparam int WAIT_LIMIT = 500;

    logic                  clock;
    logic                  arst_n;
    fir_pkg::cfg_cmd_t     cfg;
    logic                  cfg_valid;
    logic                  cfg_ready;
    logic [DATA_WIDTH-1:0] in_data;
    logic                  in_valid;
    logic                  in_ready;
    logic [DATA_WIDTH-1:0] out_data;
    logic                  out_valid;
    logic                  out_ready;

    integer seed = 16719;
    int     timeouts = 0;
    logic   bp_mode = 1'b0;

    tb_clock_gen u_clock_gen (
        .clock  (clock),
        .arst_n (arst_n)
    );

    fir_filter_top #(
        .DATA_WIDTH (DATA_WIDTH),
        .TAP_WIDTH  (TAP_WIDTH),
        .MAX_N_TAPS (MAX_N_TAPS)
    ) u_fir_filter_top (
        .clock     (clock),
        .arst_n    (arst_n),
        .cfg       (cfg),
        .cfg_valid (cfg_valid),
        .cfg_ready (cfg_ready),
        .in_data   (in_data),
        .in_valid  (in_valid),
        .in_ready  (in_ready),
        .out_data  (out_data),
        .out_valid (out_valid),
        .out_ready (out_ready)
    );

    fir_checker #(
        .DATA_WIDTH (DATA_WIDTH),
        .TAP_WIDTH  (TAP_WIDTH),
        .MAX_N_TAPS (MAX_N_TAPS)
    ) u_checker (
        .clock     (clock),
        .arst_n    (arst_n),
        .cfg       (cfg),
        .cfg_valid (cfg_valid),
        .cfg_ready (cfg_ready),
        .in_data   (in_data),
        .in_valid  (in_valid),
        .in_ready  (in_ready),
        .out_data  (out_data),
        .out_valid (out_valid),
        .out_ready (out_ready)
    );

    task automatic finish_run();
        int total;
        total = u_checker.value_errors + u_checker.protocol_errors + timeouts;
        $display("Errors: %0d value, %0d protocol, %0d timeout",
                 u_checker.value_errors, u_checker.protocol_errors, timeouts);
        if (total == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    endtask

    task automatic send_cfg(input fir_pkg::cfg_op_t op, input int addr, input int data);
        int cnt;
        cfg.op    = op;
        cfg.addr  = addr[fir_pkg::CFG_ADDR_WIDTH-1:0];
        cfg.data  = data[fir_pkg::CFG_DATA_WIDTH-1:0];
        cfg_valid = 1'b1;
        cnt = 0;
        @(posedge clock);
        while (!cfg_ready && cnt < WAIT_LIMIT) begin
            @(posedge clock);
            cnt++;
        end
        if (cnt >= WAIT_LIMIT) begin
            $display("Timed out waiting for the configuration port to accept a command");
            timeouts++;
            finish_run();
        end
        #1 cfg_valid = 1'b0;
    endtask

    task automatic send_sample(input logic [DATA_WIDTH-1:0] data, input int gap);
        int cnt;
        repeat (gap) begin
            @(posedge clock);
            #1;
        end
        in_data  = data;
        in_valid = 1'b1;
        cnt = 0;
        @(posedge clock);
        while (!in_ready && cnt < WAIT_LIMIT) begin
            @(posedge clock);
            cnt++;
        end
        if (cnt >= WAIT_LIMIT) begin
            $display("Timed out waiting for the filter to accept an input sample");
            timeouts++;
            finish_run();
        end
        #1 in_valid = 1'b0;
    endtask

    // Wait until every accepted sample has produced its output
    task automatic drain_outputs();
        int cnt;
        cnt = 0;
        while (u_checker.pending_count() != 0 && cnt < WAIT_LIMIT) begin
            @(posedge clock);
            #1;
            cnt++;
        end
        if (cnt >= WAIT_LIMIT) begin
            $display("Timed out waiting for outstanding results to come out");
            timeouts++;
            finish_run();
        end
    endtask

    task automatic stream_random(input int count, input int max_gap);
        for (int i = 0; i < count; i++) begin
            send_sample($random(seed), {$random(seed)} % (max_gap + 1));
        end
    endtask

    // Out_ready is random under back-pressure and high otherwise
    always @(posedge clock) begin
        #1 out_ready = bp_mode ? ($random(seed) & 1) : arst_n;
    end

    initial begin
        repeat (200000) @(posedge clock);
        $display("The simulation ran past its overall cycle limit");
        timeouts++;
        finish_run();
    end

    initial begin
        int cnt;
        cfg       = '0;
        cfg_valid = 1'b0;
        in_data   = '0;
        in_valid  = 1'b0;
        out_ready = 1'b0;
        cnt = 0;
        while (arst_n !== 1'b1 && cnt < WAIT_LIMIT) begin
            @(posedge clock);
            cnt++;
        end
        if (cnt >= WAIT_LIMIT) begin
            $display("Timed out waiting for reset to be released");
            timeouts++;
            finish_run();
        end
        #1;

        // First output after reset sees an all-zero history
        u_checker.test_name = "reset";
        send_cfg(fir_pkg::cfg_write_tap, 0, 16'h4000);
        send_cfg(fir_pkg::cfg_write_tap, 1, 16'h2000);
        send_cfg(fir_pkg::cfg_set_length, 0, 1);
        send_sample(16'h1234, 3);
        drain_outputs();

        u_checker.test_name = "impulse";
        for (int k = 0; k < MAX_N_TAPS; k++) begin
            send_cfg(fir_pkg::cfg_write_tap, k, $random(seed));
        end
        send_cfg(fir_pkg::cfg_set_length, 0, 7);
        send_sample(16'h7fff, 0);
        repeat (9) send_sample('0, 0);
        drain_outputs();

        u_checker.test_name = "streaming";
        repeat (4) begin
            send_cfg(fir_pkg::cfg_set_length, 0, {$random(seed)} % MAX_N_TAPS);
            stream_random(20, 2);
            drain_outputs();
        end

        u_checker.test_name = "history_clear";
        stream_random(5, 0);
        drain_outputs();
        send_cfg(fir_pkg::cfg_clear_history, 0, 0);
        stream_random(5, 1);
        drain_outputs();
        send_cfg(fir_pkg::cfg_set_length, 0, MAX_N_TAPS + 5);
        stream_random(5, 1);
        drain_outputs();

        u_checker.test_name = "back_pressure";
        bp_mode = 1'b1;
        stream_random(40, 3);
        drain_outputs();
        bp_mode = 1'b0;

        // Coefficient writes race the sample stream and land between samples
        // A short filter and long gaps leave the core idle now and then
        u_checker.test_name = "gated_config";
        send_cfg(fir_pkg::cfg_set_length, 0, 3);
        fork
            stream_random(30, 10);
            repeat (6) begin
                repeat ({$random(seed)} % 8) @(posedge clock);
                #1;
                send_cfg(fir_pkg::cfg_write_tap, {$random(seed)} % 4, $random(seed));
            end
        join
        drain_outputs();

        finish_run();
    end

endmodule

// File: tb/tb_clock_gen.sv
// Testbench clock and reset
`timescale 1ns/1ps

module tb_clock_gen #(
    parameter real PERIOD_NS    = 100.0,
    parameter int  RESET_CYCLES = 10
) (
    output logic clock,
    output logic arst_n
);

    initial begin
        clock = 1'b0;
        forever begin
            #(PERIOD_NS / 2.0) clock = ~clock;
        end
    end

    // Reset is released just after a rising edge
    initial begin
        arst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge clock);
        #1 arst_n = 1'b1;
    end

endmodule
